//--- compile.f
+incdir+include
hdl/bixb_pkg.sv
hdl/gpio_port.sv
hdl/spi_master.sv
hdl/pad_mux.sv
hdl/bixb_top.sv
testbench/tb_bixb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_bixb
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- testbench/bixb_vectors.hex
// Word: op[31:28] 1=wr 2=rd 3=pad_in 4=pads 5=spi 6=spi+collision F=end
// addr[21:16], data[15:8] (wr data, pad_in, pad_out, master), exp[7:0] (rd, pad_oe, slave)
20220019
2021001F
202D0000
4000191F
1021FF00
1022A500
202100FF
4000A5FF
10214F00
30005A00
2020005A
3000C300
202000C3
102C4000
502E3CA7
400025AF
102C4100
502E965B
102C4200
502E0FF0
102C4300
502E817E
202C0043
102C4000
602E5AC3
102C0000
4000A54F
F0000000

//--- include/tb_bixb_checks.svh
/*
 * Compare tasks and result counters, included in the testbench module body.
 * Each mismatch prints one [FAIL] line and bumps err_cnt.
 */
`ifndef TB_BIXB_CHECKS_SVH
`define TB_BIXB_CHECKS_SVH

int err_cnt  = 0;   // Mismatches over the whole run
int pass_cnt = 0;   // Tests with no mismatch
int fail_cnt = 0;

// Bus bytes and register values
task automatic check_byte(input string name, input bixb_pkg::byte_t actual,
                          input bixb_pkg::byte_t expected);
   if (actual !== expected) begin
      err_cnt++;
      $display("[FAIL] %s: expected 0x%02h, got 0x%02h", name, expected, actual);
   end
endtask

// Pad vectors, one bit per board pad
task automatic check_pad(input string name, input bixb_pkg::pad_t actual,
                         input bixb_pkg::pad_t expected);
   if (actual !== expected) begin
      err_cnt++;
      $display("[FAIL] %s: expected 0x%02h, got 0x%02h", name, expected, actual);
   end
endtask

`endif

//--- testbench/tb_bixb.sv
/*
 * Testbench for bixb_top. Replays bus and pad steps from a hex vector file,
 * models the SD card as an SPI slave and prints one line per test.
 */
`timescale 1ns/100ps

module tb_bixb;

   localparam int CLK_PERIOD = 100;
   localparam int VEC_DEPTH  = 64;
   localparam bixb_pkg::io_addr_t SPSR_ADDR = 6'h2D;
   localparam bixb_pkg::io_addr_t SPDR_ADDR = 6'h2E;
   // Op codes in vector bits 31:28
   localparam logic [3:0] OP_WRITE  = 4'h1;
   localparam logic [3:0] OP_READ   = 4'h2;
   localparam logic [3:0] OP_PAD_IN = 4'h3;
   localparam logic [3:0] OP_PADS   = 4'h4;
   localparam logic [3:0] OP_SPI    = 4'h5;
   localparam logic [3:0] OP_WCOL   = 4'h6;   // SPI with a colliding second write
   localparam logic [3:0] OP_END    = 4'hF;

   logic               clk = 1'b0;
   logic               rst_n;
   bixb_pkg::io_addr_t adr;
   bixb_pkg::byte_t    dbus_in;
   logic               iore;
   logic               iowe;
   bixb_pkg::pad_t     pad_in;
   bixb_pkg::byte_t    dbus_out;
   logic               io_out_en;
   bixb_pkg::pad_t     pad_out;
   bixb_pkg::pad_t     pad_oe;

   logic [31:0]        vectors [0:VEC_DEPTH-1];
   int                 n_vec;
   int                 cycle_cnt = 0;
   int                 cycle_limit;

   bixb_pkg::pad_t     pad_drive;      // Pad levels set by the vectors
   bixb_pkg::byte_t    slave_byte;     // Byte the card sends back
   logic               slave_active;   // Card owns MISO during a transfer
   bixb_pkg::byte_t    slave_rx;       // Byte the card received
   logic [2:0]         slave_cnt;      // Bits already sent, wraps after 8
   logic               sck_prev;

   `include "tb_bixb_checks.svh"

   bixb_top #(
      .SPSR_ADDR (SPSR_ADDR),
      .SPDR_ADDR (SPDR_ADDR)
   ) dut0 (
      .clk (clk), .rst_n (rst_n),
      .adr (adr), .dbus_in (dbus_in), .iore (iore), .iowe (iowe),
      .dbus_out (dbus_out), .io_out_en (io_out_en),
      .pad_in (pad_in), .pad_out (pad_out), .pad_oe (pad_oe)
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   // Watchdog ------------------------------
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("Run timed out after %0d cycles", cycle_cnt);
         $display("*** FAILED ***");
         $finish;
      end
   end

   // SD card model, mode 0, edges seen at the falling clk
   always @(negedge clk) begin
      if (!rst_n) begin
         slave_cnt <= 3'd0;
         slave_rx  <= '0;
         sck_prev  <= 1'b0;
      end else begin
         sck_prev <= pad_out[bixb_pkg::PAD_SCK];
         if (slave_active && !sck_prev && pad_out[bixb_pkg::PAD_SCK]) begin
            slave_rx <= {slave_rx[6:0], pad_out[bixb_pkg::PAD_MOSI]};   // Rise samples
         end else if (slave_active && sck_prev && !pad_out[bixb_pkg::PAD_SCK]) begin
            slave_cnt <= slave_cnt + 3'd1;                             // Fall shifts
         end
      end
   end

   always_comb begin
      pad_in = pad_drive;
      if (slave_active) begin
         pad_in[bixb_pkg::PAD_MISO] = slave_byte[3'd7 - slave_cnt];    // MSB first
      end
   end

   // Bus access ----------------------------
   task automatic bus_write(input bixb_pkg::io_addr_t a, input bixb_pkg::byte_t d);
      @(negedge clk);
      adr     = a;
      dbus_in = d;
      iowe    = 1'b1;
      @(negedge clk);
      iowe    = 1'b0;
   endtask

   task automatic bus_read(input bixb_pkg::io_addr_t a, output bixb_pkg::byte_t d);
      @(negedge clk);
      adr  = a;
      iore = 1'b1;
      #(CLK_PERIOD/4);                   // Mid low phase, read data settled
      d = dbus_out;
      if (io_out_en !== 1'b1) begin
         err_cnt++;
         $display("Read of address 0x%02h got no io_out_en from the DUT", a);
      end
      @(negedge clk);
      iore = 1'b0;
   endtask

   // One byte exchange, polled on SPIF
   task automatic spi_transfer(input bixb_pkg::byte_t master, input bixb_pkg::byte_t slave,
                               input logic collide);
      bixb_pkg::byte_t status;
      @(negedge clk);
      slave_byte   = slave;
      slave_active = 1'b1;
      bus_write(SPDR_ADDR, master);
      if (collide) begin
         bus_write(SPDR_ADDR, ~master);  // Lands mid transfer
      end
      status = '0;
      while (!status[bixb_pkg::SPSR_SPIF]) begin
         bus_read(SPSR_ADDR, status);
      end
      check_byte("SPSR", status, collide ? 8'hC0 : 8'h80);
      bus_read(SPDR_ADDR, status);
      check_byte("SPDR", status, slave);
      check_byte("slave_rx", slave_rx, master);
      bus_read(SPSR_ADDR, status);
      check_byte("SPSR after SPDR read", status, 8'h00);
      slave_active = 1'b0;
   endtask

   function automatic logic vector_valid(input logic [31:0] vec);
      return !$isunknown(vec) && vec[31:28] != OP_END && vec[31:28] != 4'h0;
   endfunction

   task automatic run_vector(input int idx, input logic [31:0] vec);
      logic [3:0]         op;
      bixb_pkg::io_addr_t a;
      bixb_pkg::byte_t    d;
      bixb_pkg::byte_t    e;
      bixb_pkg::byte_t    got;
      int                 errs_before;
      op = vec[31:28];
      a  = vec[21:16];
      d  = vec[15:8];
      e  = vec[7:0];
      errs_before = err_cnt;
      case (op)
         OP_WRITE: bus_write(a, d);
         OP_READ: begin
            bus_read(a, got);
            check_byte($sformatf("dbus_out[0x%02h]", a), got, e);
         end
         OP_PAD_IN: begin
            @(negedge clk);
            pad_drive = d;
            repeat (3) @(negedge clk);   // Through the PIN synchronizer
         end
         OP_PADS: begin
            @(negedge clk);
            #(CLK_PERIOD/4);
            check_pad("pad_out", pad_out, d);
            check_pad("pad_oe", pad_oe, e);
         end
         OP_SPI: spi_transfer(d, e, 1'b0);
         OP_WCOL: spi_transfer(d, e, 1'b1);
         default: begin
            err_cnt++;
            $display("Vector %0d has an unknown op code %0h", idx, op);
         end
      endcase
      if (err_cnt == errs_before) begin
         pass_cnt++;
         $display("test %0d op %0h addr 0x%02h: ok", idx, op, a);
      end else begin
         fail_cnt++;
         $display("test %0d op %0h addr 0x%02h: mismatch", idx, op, a);
      end
   endtask

   // Main sequence -------------------------
   initial begin
      rst_n        = 1'b0;
      adr          = '0;
      dbus_in      = '0;
      iore         = 1'b0;
      iowe         = 1'b0;
      pad_drive    = '0;
      slave_byte   = '0;
      slave_active = 1'b0;
      $readmemh("testbench/bixb_vectors.hex", vectors);
      n_vec = 0;
      while (n_vec < VEC_DEPTH && vector_valid(vectors[n_vec])) begin
         n_vec++;
      end
      cycle_limit = n_vec * 8 * 128 + 200;   // Slowest byte plus slack per vector
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      if (n_vec == 0) begin
         err_cnt++;
         $display("No test vectors were loaded");
      end
      for (int i = 0; i < n_vec; i++) begin
         run_vector(i, vectors[i]);
      end
      $display("Summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
      if (err_cnt == 0 && fail_cnt == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- hdl/bixb_top.sv
/*
 * BIXB top: GPIO port and SPI master on the I/O bus, merged onto 8 pads.
 * The register addresses are set here and passed to the two blocks.
 */
`timescale 1ns/100ps

module bixb_top #(
   parameter bixb_pkg::io_addr_t PIN_ADDR  = 6'h20,
   parameter bixb_pkg::io_addr_t DDR_ADDR  = 6'h21,
   parameter bixb_pkg::io_addr_t PORT_ADDR = 6'h22,
   parameter bixb_pkg::io_addr_t SPCR_ADDR = 6'h2C,
   parameter bixb_pkg::io_addr_t SPSR_ADDR = 6'h2D,
   parameter bixb_pkg::io_addr_t SPDR_ADDR = 6'h2E
) (
   input  logic               clk,
   input  logic               rst_n,
   // I/O bus
   input  bixb_pkg::io_addr_t adr,
   input  bixb_pkg::byte_t    dbus_in,
   input  logic               iore,
   input  logic               iowe,
   output bixb_pkg::byte_t    dbus_out,
   output logic               io_out_en,
   // Pads
   input  bixb_pkg::pad_t     pad_in,
   output bixb_pkg::pad_t     pad_out,
   output bixb_pkg::pad_t     pad_oe
);

   bixb_pkg::byte_t  gpio_dbus_out, spi_dbus_out;
   logic             gpio_out_en, spi_out_en;
   bixb_pkg::byte_t  portx, ddrx;
   logic             spe, sck, mosi, miso;

   // GPIO port ------------------------------
   gpio_port #(
      .PIN_ADDR  (PIN_ADDR),
      .DDR_ADDR  (DDR_ADDR),
      .PORT_ADDR (PORT_ADDR)
   ) gpio_port0 (
      .clk (clk), .rst_n (rst_n),
      .adr (adr), .dbus_in (dbus_in), .iore (iore), .iowe (iowe),
      .dbus_out (gpio_dbus_out), .out_en (gpio_out_en),
      .pin_in (pad_in),              // Raw pads, synchronized inside
      .portx (portx), .ddrx (ddrx)
   );

   // SD card SPI master
   spi_master #(
      .SPCR_ADDR (SPCR_ADDR),
      .SPSR_ADDR (SPSR_ADDR),
      .SPDR_ADDR (SPDR_ADDR)
   ) spi_master0 (
      .clk (clk), .rst_n (rst_n),
      .adr (adr), .dbus_in (dbus_in), .iore (iore), .iowe (iowe),
      .dbus_out (spi_dbus_out), .out_en (spi_out_en),
      .miso (miso), .spe (spe), .sck (sck), .mosi (mosi)
   );

   pad_mux pad_mux0 (
      .portx (portx), .ddrx (ddrx),
      .spe (spe), .sck (sck), .mosi (mosi), .miso (miso),
      .pad_in (pad_in), .pad_out (pad_out), .pad_oe (pad_oe)
   );

   // Each block zeroes its byte when not selected, addresses never overlap
   assign dbus_out  = gpio_dbus_out | spi_dbus_out;
   assign io_out_en = gpio_out_en | spi_out_en;

endmodule

//--- hdl/pad_mux.sv
/*
 * Pad multiplexer. GPIO owns every pad by default; an enabled SPI takes
 * sck and mosi as outputs and turns miso into an input. Purely combinational.
 */
`timescale 1ns/100ps

module pad_mux (
   // GPIO side
   input  bixb_pkg::byte_t portx,
   input  bixb_pkg::byte_t ddrx,
   // SPI side
   input  logic            spe,
   input  logic            sck,
   input  logic            mosi,
   output logic            miso,
   // Pads
   input  bixb_pkg::pad_t  pad_in,
   output bixb_pkg::pad_t  pad_out,
   output bixb_pkg::pad_t  pad_oe      // 1 = pad driven
);

   // Default control from DDR and PORT ---
   always_comb begin
      pad_oe  = ddrx;
      pad_out = portx;

      // SPI override, master only
      if (spe) begin
         pad_oe[bixb_pkg::PAD_SCK]   = 1'b1;
         pad_out[bixb_pkg::PAD_SCK]  = sck;
         pad_oe[bixb_pkg::PAD_MOSI]  = 1'b1;
         pad_out[bixb_pkg::PAD_MOSI] = mosi;
         pad_oe[bixb_pkg::PAD_MISO]  = 1'b0;  // Card drives this one
         pad_out[bixb_pkg::PAD_MISO] = 1'b0;
      end
   end

   // MISO straight from the pad, the SPI samples it on its own schedule
   assign miso = pad_in[bixb_pkg::PAD_MISO];

endmodule

//--- hdl/spi_master.sv
/*
 * SPI master, mode 0, MSB first, with AVR-style SPCR/SPSR/SPDR registers.
 * Software writes SPDR to start a byte and polls SPIF for the end of it.
 */
`timescale 1ns/100ps

module spi_master #(
   parameter bixb_pkg::io_addr_t SPCR_ADDR = 6'h2C,
   parameter bixb_pkg::io_addr_t SPSR_ADDR = 6'h2D,
   parameter bixb_pkg::io_addr_t SPDR_ADDR = 6'h2E
) (
   input  logic               clk,
   input  logic               rst_n,
   // I/O bus
   input  bixb_pkg::io_addr_t adr,
   input  bixb_pkg::byte_t    dbus_in,
   input  logic               iore,
   input  logic               iowe,
   output bixb_pkg::byte_t    dbus_out,   // Zero unless out_en
   output logic               out_en,
   // SPI pins
   input  logic               miso,
   output logic               spe,        // Pad override request
   output logic               sck,
   output logic               mosi
);

   logic                   spcr_sel, spsr_sel, spdr_sel;
   logic                   spdr_wr;    // Bus write to SPDR this cycle
   logic                   spdr_rd;    // Bus read of SPDR this cycle
   bixb_pkg::byte_t        spcr;
   bixb_pkg::spi_rate_t    rate;
   logic [6:0]             half;       // Half-period for the current rate
   bixb_pkg::byte_t        shreg;      // Shift register, doubles as SPDR
   logic                   spif;
   logic                   wcol;
   logic                   busy;
   logic                   start;
   logic                   tick;       // SCK edge this cycle
   logic                   done;       // Last falling edge
   logic                   sck_q;
   logic                   miso_smp;   // Bit caught on the rising edge
   logic [6:0]             div_cnt;
   logic [3:0]             edge_cnt;   // Counts 16 half-periods

   // Decode --------------------------------------
   assign spcr_sel = (adr == SPCR_ADDR);
   assign spsr_sel = (adr == SPSR_ADDR);
   assign spdr_sel = (adr == SPDR_ADDR);
   assign spdr_wr  = iowe && spdr_sel;
   assign spdr_rd  = iore && spdr_sel;

   assign spe  = spcr[bixb_pkg::SPCR_SPE];
   assign rate = spcr[bixb_pkg::SPCR_SPR +: 2];
   assign half = bixb_pkg::spi_half_period(rate);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         spcr <= '0;
      end else if (iowe && spcr_sel) begin
         spcr <= dbus_in;
      end
   end

   // Clock divider and edge sequencing -----------
   assign start = spdr_wr && spe && !busy;
   assign tick  = busy && (div_cnt == 7'd0);
   assign done  = tick && (edge_cnt == 4'd15);   // SCK returns low here

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy     <= 1'b0;
         sck_q    <= 1'b0;
         div_cnt  <= '0;
         edge_cnt <= '0;
      end else if (!spe) begin
         busy  <= 1'b0;                      // Disabling aborts a transfer
         sck_q <= 1'b0;
      end else if (start) begin
         busy     <= 1'b1;
         div_cnt  <= half - 7'd1;
         edge_cnt <= '0;
      end else if (tick) begin
         div_cnt  <= half - 7'd1;
         sck_q    <= ~sck_q;
         edge_cnt <= edge_cnt + 4'd1;
         if (done) begin
            busy <= 1'b0;
         end
      end else if (busy) begin
         div_cnt <= div_cnt - 7'd1;
      end
   end

   // Data path: sample on rise, shift on fall
   always_ff @(posedge clk) begin
      if (tick && !sck_q) begin
         miso_smp <= miso;
      end
   end

   always_ff @(posedge clk) begin
      if (spdr_wr && !busy) begin
         shreg <= dbus_in;                   // Collisions leave it alone
      end else if (tick && sck_q) begin
         shreg <= {shreg[6:0], miso_smp};
      end
   end

   // Status flags, completion wins over a clear
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         spif <= 1'b0;
         wcol <= 1'b0;
      end else begin
         if (done) begin
            spif <= 1'b1;
         end else if (spdr_rd || spdr_wr) begin
            spif <= 1'b0;
         end
         if (spdr_wr && busy) begin
            wcol <= 1'b1;
         end else if (spdr_rd || spdr_wr) begin
            wcol <= 1'b0;
         end
      end
   end

   // Read back -----------------------------------
   assign out_en = iore && (spcr_sel || spsr_sel || spdr_sel);

   always_comb begin
      dbus_out = '0;
      if (out_en) begin
         if (spcr_sel) begin
            dbus_out = spcr;
         end else if (spsr_sel) begin
            dbus_out[bixb_pkg::SPSR_SPIF] = spif;
            dbus_out[bixb_pkg::SPSR_WCOL] = wcol;
         end else begin
            dbus_out = shreg;
         end
      end
   end

   assign sck  = sck_q;
   assign mosi = shreg[7];                   // MSB first, valid before first rise

endmodule

//--- hdl/gpio_port.sv
/*
 * AVR-style 8-bit GPIO port: PORT and DDR registers plus a synchronized PIN.
 * PORT and DDR go straight to the pad mux; PIN reads come through two flops.
 */
`timescale 1ns/100ps

module gpio_port #(
   parameter bixb_pkg::io_addr_t PIN_ADDR  = 6'h20,
   parameter bixb_pkg::io_addr_t DDR_ADDR  = 6'h21,
   parameter bixb_pkg::io_addr_t PORT_ADDR = 6'h22
) (
   input  logic               clk,
   input  logic               rst_n,
   // I/O bus
   input  bixb_pkg::io_addr_t adr,
   input  bixb_pkg::byte_t    dbus_in,
   input  logic               iore,
   input  logic               iowe,
   output bixb_pkg::byte_t    dbus_out,   // Zero unless out_en
   output logic               out_en,
   // Pad side
   input  bixb_pkg::pad_t     pin_in,     // Raw pad values, asynchronous
   output bixb_pkg::byte_t    portx,      // Output values to pad mux
   output bixb_pkg::byte_t    ddrx        // Directions to pad mux, 1 = output
);

   logic              pin_sel;
   logic              ddr_sel;
   logic              port_sel;
   bixb_pkg::pad_t    pin_meta;           // First synchronizer stage
   bixb_pkg::pad_t    pin_sync;           // Second stage, what PIN returns

   // Address decode ------------------------------
   assign pin_sel  = (adr == PIN_ADDR);
   assign ddr_sel  = (adr == DDR_ADDR);
   assign port_sel = (adr == PORT_ADDR);

   // Control registers, PIN is read only
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ddrx  <= bixb_pkg::GPIO_DDR_RST;
         portx <= bixb_pkg::GPIO_PORT_RST;
      end else if (iowe) begin
         if (ddr_sel) begin
            ddrx <= dbus_in;
         end
         if (port_sel) begin
            portx <= dbus_in;
         end
      end
   end

   // Two-flop synchronizer on the pad inputs
   always_ff @(posedge clk) begin
      pin_meta <= pin_in;
      pin_sync <= pin_meta;
   end

   // Read back -----------------------------------
   assign out_en = iore && (pin_sel || ddr_sel || port_sel);

   always_comb begin
      dbus_out = '0;
      if (out_en) begin
         if (pin_sel) begin
            dbus_out = pin_sync;
         end else if (ddr_sel) begin
            dbus_out = ddrx;
         end else begin
            dbus_out = portx;               // Only PORT is left
         end
      end
   end

endmodule

//--- hdl/bixb_pkg.sv
/*
 * Shared types and constants for the BIXB peripheral (GPIO port, SPI master, pad mux).
 * Referenced with scoped names from every RTL file and the testbench.
 */
package bixb_pkg;

   typedef logic [7:0] byte_t;      // Bus data byte / register value
   typedef logic [5:0] io_addr_t;   // I/O space address
   typedef logic [7:0] pad_t;       // One bit per board pad
   typedef logic [1:0] spi_rate_t;  // SPR code

   // Pad positions ------------------------------
   localparam int PAD_CFG    = 0;   // Module config strap
   localparam int PAD_RESETN = 1;   // Module hard reset, low active
   localparam int PAD_WAKE   = 2;
   localparam int PAD_ENABLE = 3;   // Module chip enable
   localparam int PAD_SS     = 4;   // SD card slave select
   localparam int PAD_MOSI   = 5;   // GPIO bit 5 while SPI is off
   localparam int PAD_MISO   = 6;   // GPIO bit 6 while SPI is off
   localparam int PAD_SCK    = 7;   // GPIO bit 7 while SPI is off

   // SPI register fields ------------------------
   localparam int SPCR_SPE  = 6;    // SPI enable
   localparam int SPCR_SPR  = 0;    // Rate select, LSB of a 2-bit field
   localparam int SPSR_SPIF = 7;    // Transfer complete
   localparam int SPSR_WCOL = 6;    // Write collision

   // GPIO reset state: cfg, enable and SS driven high, module held in reset
   localparam byte_t GPIO_DDR_RST  = 8'h1F;
   localparam byte_t GPIO_PORT_RST = 8'h19;

   // SCK half-period in clk cycles, full period is clk/4, /16, /64, /128
   function automatic logic [6:0] spi_half_period(input spi_rate_t rate);
      case (rate)
         2'd0:    return 7'd2;
         2'd1:    return 7'd8;
         2'd2:    return 7'd32;
         default: return 7'd64;
      endcase
   endfunction

endpackage
